/* include/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data and address width
`define CORE_XLEN 32

// architectural registers
`define CORE_NREGS 32

// first fetch address out of reset
`define CORE_RESET_PC 32'h0000_0000

`endif

/* hw/isa_pkg.sv */
package isa_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} funct_e;

	typedef struct packed {
		opcode_e    opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e     funct;
	} r_view_t;

	// jump target is the low 26 bits of this view
	typedef struct packed {
		opcode_e     opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_view_t;

	typedef union packed {
		r_view_t r_view;
		i_view_t i_view;
	} instr_u;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI
	} alu_op_e;

endpackage

/* hw/pipe_pkg.sv */
`include "core_defs.svh"

package pipe_pkg;

	import isa_pkg::*;

	typedef logic [`CORE_XLEN-1:0] word_t;
	typedef logic [$clog2(`CORE_NREGS)-1:0] reg_addr_t;

	typedef struct packed {
		alu_op_e alu_op;
		logic    alu_src_imm;
		// result is pc+8
		logic    link;
		logic    mem_read;
		logic    mem_write;
		logic    reg_write;
	} ctrl_t;

	typedef struct packed {
		logic  valid;
		word_t pc4;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     pc4;
		word_t     rs_val;
		word_t     rt_val;
		word_t     imm;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dest;
	} id_ex_t;

	typedef struct packed {
		logic      mem_read;
		logic      mem_write;
		logic      reg_write;
		word_t     alu_res;
		word_t     store_data;
		reg_addr_t dest;
	} ex_mem_t;

	typedef struct packed {
		logic      reg_write;
		word_t     wdata;
		reg_addr_t dest;
	} mem_wb_t;

	// register written by the instruction held in ID/EX
	function automatic reg_addr_t ex_dest(id_ex_t r);
		if (r.ctrl.link)
			return reg_addr_t'(`CORE_NREGS - 1);
		return r.ctrl.alu_src_imm ? r.rt : r.dest;
	endfunction

endpackage

/* hw/fetch.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module fetch import pipe_pkg::*; (
	input  logic   i_clk,
	input  logic   i_rst_n,
	input  logic   i_stall,
	input  logic   i_take,
	input  word_t  i_target,
	input  word_t  i_instr,
	output word_t  o_pc,
	output if_id_t o_if_id
	);

	word_t pc4;

	assign pc4 = o_pc + word_t'(4);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_pc    <= `CORE_RESET_PC;
			o_if_id <= '0;
		end else if (!i_stall) begin
			// redirect lands after the delay slot
			o_pc          <= i_take ? i_target : pc4;
			o_if_id.valid <= 1'b1;
			o_if_id.pc4   <= pc4;
			o_if_id.instr <= i_instr;
		end
	end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module reg_file import pipe_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_we,
	input  reg_addr_t i_waddr,
	input  word_t     i_wdata,
	input  reg_addr_t i_raddr_a,
	input  reg_addr_t i_raddr_b,
	output word_t     o_rdata_a,
	output word_t     o_rdata_b
	);

	word_t regs [`CORE_NREGS];

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `CORE_NREGS; i++)
				regs[i] <= '0;
		end else if (i_we && i_waddr != '0) begin
			regs[i_waddr] <= i_wdata;
		end
	end

	// write-through so decode sees the writeback value
	assign o_rdata_a = (i_raddr_a == '0) ? '0 :
		(i_we && i_waddr == i_raddr_a) ? i_wdata : regs[i_raddr_a];
	assign o_rdata_b = (i_raddr_b == '0) ? '0 :
		(i_we && i_waddr == i_raddr_b) ? i_wdata : regs[i_raddr_b];

endmodule

/* hw/decode.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module decode import isa_pkg::*, pipe_pkg::*; (
	input  logic    i_clk,
	input  logic    i_rst_n,
	input  if_id_t  i_if_id,
	input  mem_wb_t i_mem_wb,
	input  ex_mem_t i_ex_mem,
	output id_ex_t  o_id_ex,
	output logic    o_stall,
	output logic    o_take,
	output word_t   o_target
	);

	instr_u    instr;
	ctrl_t     ctrl;
	word_t     imm_ext;
	word_t     rs_val;
	word_t     rt_val;
	word_t     rs_cmp;
	word_t     rt_cmp;
	reg_addr_t ex_dst;
	logic      is_beq;
	logic      is_bne;
	logic      is_jump;
	logic      is_jr;
	logic      use_rs;
	logic      use_rt;
	logic      ex_hit;
	logic      mem_hit;
	logic      load_use;
	logic      br_hazard;
	id_ex_t    id_ex_d;

	assign instr   = i_if_id.instr;
	assign imm_ext = {{(`CORE_XLEN-16){instr.i_view.imm[15]}}, instr.i_view.imm};

	reg_file u_reg_file(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_we(i_mem_wb.reg_write),
		.i_waddr(i_mem_wb.dest),
		.i_wdata(i_mem_wb.wdata),
		.i_raddr_a(instr.i_view.rs),
		.i_raddr_b(instr.i_view.rt),
		.o_rdata_a(rs_val),
		.o_rdata_b(rt_val)
		);

	always_comb begin
		ctrl    = '0;
		is_beq  = 1'b0;
		is_bne  = 1'b0;
		is_jump = 1'b0;
		is_jr   = 1'b0;
		use_rs  = 1'b0;
		use_rt  = 1'b0;
		case (instr.i_view.opcode)
			OP_RTYPE: begin
				use_rs         = 1'b1;
				use_rt         = 1'b1;
				ctrl.reg_write = 1'b1;
				case (instr.r_view.funct)
					FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_SLT:  ctrl.alu_op = ALU_SLT;
					FN_JR: begin
						ctrl.reg_write = 1'b0;
						use_rt         = 1'b0;
						is_jr          = 1'b1;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				use_rs           = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write   = 1'b1;
			end
			OP_LUI: begin
				ctrl.alu_op      = ALU_LUI;
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write   = 1'b1;
			end
			OP_LW: begin
				use_rs           = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_read    = 1'b1;
				ctrl.reg_write   = 1'b1;
			end
			OP_SW: begin
				use_rs           = 1'b1;
				use_rt           = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write   = 1'b1;
			end
			OP_BEQ: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				is_beq = 1'b1;
			end
			OP_BNE: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				is_bne = 1'b1;
			end
			OP_J: is_jump = 1'b1;
			OP_JAL: begin
				is_jump        = 1'b1;
				ctrl.link      = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			default: ;
		endcase
	end

	// branch operands take the EX/MEM result, WB comes through the register file
	always_comb begin
		rs_cmp = rs_val;
		rt_cmp = rt_val;
		if (i_ex_mem.reg_write && i_ex_mem.dest != '0) begin
			if (i_ex_mem.dest == instr.i_view.rs)
				rs_cmp = i_ex_mem.alu_res;
			if (i_ex_mem.dest == instr.i_view.rt)
				rt_cmp = i_ex_mem.alu_res;
		end
	end

	assign ex_dst  = ex_dest(o_id_ex);
	assign ex_hit  = ex_dst != '0 && ((use_rs && ex_dst == instr.i_view.rs) ||
		(use_rt && ex_dst == instr.i_view.rt));
	assign mem_hit = i_ex_mem.dest != '0 && ((use_rs && i_ex_mem.dest == instr.i_view.rs) ||
		(use_rt && i_ex_mem.dest == instr.i_view.rt));

	assign load_use  = o_id_ex.ctrl.mem_read && ex_hit;
	// compare happens here, so sources still in flight must wait
	assign br_hazard = (is_beq || is_bne || is_jr) &&
		((o_id_ex.ctrl.reg_write && ex_hit) || (i_ex_mem.mem_read && mem_hit));
	assign o_stall   = i_if_id.valid && (load_use || br_hazard);

	always_comb begin
		o_take   = 1'b0;
		o_target = i_if_id.pc4 + {imm_ext[`CORE_XLEN-3:0], 2'b00};
		if (is_beq)
			o_take = rs_cmp == rt_cmp;
		if (is_bne)
			o_take = rs_cmp != rt_cmp;
		if (is_jump) begin
			o_take   = 1'b1;
			o_target = {i_if_id.pc4[`CORE_XLEN-1:28], instr.i_view[25:0], 2'b00};
		end
		if (is_jr) begin
			o_take   = 1'b1;
			o_target = rs_cmp;
		end
		if (!i_if_id.valid || o_stall)
			o_take = 1'b0;
	end

	always_comb begin
		// bubble on stall
		id_ex_d.ctrl   = (i_if_id.valid && !o_stall) ? ctrl : '0;
		id_ex_d.pc4    = i_if_id.pc4;
		id_ex_d.rs_val = rs_val;
		id_ex_d.rt_val = rt_val;
		id_ex_d.imm    = imm_ext;
		id_ex_d.rs     = instr.i_view.rs;
		id_ex_d.rt     = instr.i_view.rt;
		id_ex_d.dest   = instr.r_view.rd;
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n)
			o_id_ex <= '0;
		else
			o_id_ex <= id_ex_d;
	end

endmodule

/* hw/execute.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module execute import isa_pkg::*, pipe_pkg::*; (
	input  logic    i_clk,
	input  logic    i_rst_n,
	input  id_ex_t  i_id_ex,
	input  mem_wb_t i_mem_wb,
	output ex_mem_t o_ex_mem
	);

	word_t     op_a;
	word_t     op_rt;
	word_t     op_b;
	word_t     alu_res;
	reg_addr_t dest;

	// newest producer wins
	function automatic word_t fwd(reg_addr_t src, word_t val, ex_mem_t em, mem_wb_t wb);
		word_t res;
		res = val;
		if (src != '0) begin
			if (em.reg_write && em.dest == src)
				res = em.alu_res;
			else if (wb.reg_write && wb.dest == src)
				res = wb.wdata;
		end
		return res;
	endfunction

	assign op_a  = fwd(i_id_ex.rs, i_id_ex.rs_val, o_ex_mem, i_mem_wb);
	assign op_rt = fwd(i_id_ex.rt, i_id_ex.rt_val, o_ex_mem, i_mem_wb);
	assign op_b  = i_id_ex.ctrl.alu_src_imm ? i_id_ex.imm : op_rt;

	always_comb begin
		case (i_id_ex.ctrl.alu_op)
			ALU_ADD: alu_res = op_a + op_b;
			ALU_SUB: alu_res = op_a - op_b;
			ALU_AND: alu_res = op_a & op_b;
			ALU_OR:  alu_res = op_a | op_b;
			ALU_SLT: alu_res = word_t'($signed(op_a) < $signed(op_b));
			ALU_LUI: alu_res = {op_b[15:0], {(`CORE_XLEN-16){1'b0}}};
			default: alu_res = '0;
		endcase
		// return address skips the delay slot
		if (i_id_ex.ctrl.link)
			alu_res = i_id_ex.pc4 + word_t'(4);
	end

	assign dest = ex_dest(i_id_ex);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_ex_mem <= '0;
		end else begin
			o_ex_mem.mem_read   <= i_id_ex.ctrl.mem_read;
			o_ex_mem.mem_write  <= i_id_ex.ctrl.mem_write;
			o_ex_mem.reg_write  <= i_id_ex.ctrl.reg_write;
			o_ex_mem.alu_res    <= alu_res;
			o_ex_mem.store_data <= op_rt;
			o_ex_mem.dest       <= dest;
		end
	end

endmodule

/* hw/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage import pipe_pkg::*; (
	input  logic    i_clk,
	input  logic    i_rst_n,
	input  ex_mem_t i_ex_mem,
	input  word_t   i_rdata,
	output mem_wb_t o_mem_wb
	);

	word_t wb_val;

	// load data or alu result
	assign wb_val = i_ex_mem.mem_read ? i_rdata : i_ex_mem.alu_res;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_mem_wb <= '0;
		end else begin
			o_mem_wb.reg_write <= i_ex_mem.reg_write;
			o_mem_wb.wdata     <= wb_val;
			o_mem_wb.dest      <= i_ex_mem.dest;
		end
	end

endmodule

/* hw/core.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic [`CORE_XLEN-1:0] i_instr,
	input  logic [`CORE_XLEN-1:0] i_dmem_rdata,
	output logic [`CORE_XLEN-1:0] o_imem_addr,
	output logic [`CORE_XLEN-1:0] o_dmem_addr,
	output logic [`CORE_XLEN-1:0] o_dmem_wdata,
	output logic                  o_dmem_we,
	output logic                  o_dmem_re
	);

	pipe_pkg::if_id_t      if_id;
	pipe_pkg::id_ex_t      id_ex;
	pipe_pkg::ex_mem_t     ex_mem;
	pipe_pkg::mem_wb_t     mem_wb;
	logic                  stall;
	logic                  take;
	logic [`CORE_XLEN-1:0] target;

	fetch u_fetch(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_stall(stall),
		.i_take(take),
		.i_target(target),
		.i_instr(i_instr),
		.o_pc(o_imem_addr),
		.o_if_id(if_id)
		);

	decode u_decode(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_if_id(if_id),
		.i_mem_wb(mem_wb),
		.i_ex_mem(ex_mem),
		.o_id_ex(id_ex),
		.o_stall(stall),
		.o_take(take),
		.o_target(target)
		);

	execute u_execute(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_id_ex(id_ex),
		.i_mem_wb(mem_wb),
		.o_ex_mem(ex_mem)
		);

	mem_stage u_mem_stage(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_ex_mem(ex_mem),
		.i_rdata(i_dmem_rdata),
		.o_mem_wb(mem_wb)
		);

	// data port straight off EX/MEM
	assign o_dmem_addr  = ex_mem.alu_res;
	assign o_dmem_wdata = ex_mem.store_data;
	assign o_dmem_we    = ex_mem.mem_write;
	assign o_dmem_re    = ex_mem.mem_read;

endmodule

/* verif/core_tb.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_tb import isa_pkg::*; ();

	localparam int ROM_WORDS  = 512;
	localparam int RAM_WORDS  = 256;
	localparam int MAX_STORES = 128;
	localparam int MAX_STEPS  = 4000;
	localparam int LOAD_BASE  = 512;

	logic        clk;
	logic        rst_n;
	logic [31:0] i_instr;
	logic [31:0] i_dmem_rdata;
	logic [31:0] o_imem_addr;
	logic [31:0] o_dmem_addr;
	logic [31:0] o_dmem_wdata;
	logic        o_dmem_we;
	logic        o_dmem_re;

	logic [31:0] rom [0:ROM_WORDS-1];
	logic [31:0] ram [0:RAM_WORDS-1];
	logic [31:0] model_mem [0:RAM_WORDS-1];
	logic [31:0] exp_addr [0:MAX_STORES-1];
	logic [31:0] exp_data [0:MAX_STORES-1];
	int          exp_test [0:MAX_STORES-1];
	int          sec_start [2:5];
	int          test_errs [1:6];
	string       test_name [1:6];
	logic [31:0] rng = 32'd35;
	logic [31:0] halt_pc;
	int          pc_idx;
	int          n_exp;
	int          n_seen;
	int          n_steps;
	int          limit_cycles;
	int          errors;
	int          passed;
	int          failed;
	int          store_tag;

	core i_dut(
		.i_clk(clk),
		.i_rst_n(rst_n),
		.i_instr(i_instr),
		.i_dmem_rdata(i_dmem_rdata),
		.o_imem_addr(o_imem_addr),
		.o_dmem_addr(o_dmem_addr),
		.o_dmem_wdata(o_dmem_wdata),
		.o_dmem_we(o_dmem_we),
		.o_dmem_re(o_dmem_re)
		);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// reads are combinational and data writes land at the edge
	assign i_instr      = rom[o_imem_addr[10:2]];
	assign i_dmem_rdata = ram[o_dmem_addr[9:2]];

	always @(posedge clk) begin
		if (o_dmem_we)
			ram[o_dmem_addr[9:2]] <= o_dmem_wdata;
	end

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [31:0] fill_word(int idx);
		return (32'(idx) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
	endfunction

	function automatic logic [31:0] rtype_word(funct_e fn, int rd, int rs, int rt);
		return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] itype_word(opcode_e op, int rs, int rt, int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic logic [31:0] jtype_word(opcode_e op, int idx);
		return {op, 26'(idx)};
	endfunction

	task automatic emit(logic [31:0] w);
		rom[pc_idx] = w;
		pc_idx++;
	endtask

	function automatic int section_of(logic [31:0] pc);
		int t;
		t = 2;
		for (int s = 3; s <= 5; s++)
			if (int'(pc >> 2) >= sec_start[s])
				t = s;
		return t;
	endfunction

	task automatic build_program();
		logic [31:0] r;
		int          k;
		int          sel;
		int          rd;
		int          rs;
		int          rt;
		int          prev;
		int          slot;
		int          addr;
		slot = 0;
		prev = 1;
		pc_idx = 0;
		// random alu ops with each result stored
		sec_start[2] = pc_idx;
		for (k = 0; k < 20; k++) begin
			sel = int'(next_random() % 7);
			rd  = 1 + int'(next_random() % 7);
			r   = next_random();
			rs  = r[3] ? prev : int'(r[2:0]);
			rt  = int'(r[6:4]);
			case (sel)
				0: emit(rtype_word(FN_ADDU, rd, rs, rt));
				1: emit(rtype_word(FN_SUBU, rd, rs, rt));
				2: emit(rtype_word(FN_AND, rd, rs, rt));
				3: emit(rtype_word(FN_OR, rd, rs, rt));
				4: emit(rtype_word(FN_SLT, rd, rs, rt));
				5: emit(itype_word(OP_ADDIU, rs, rd, int'(r[31:16])));
				default: emit(itype_word(OP_LUI, 0, rd, int'(r[31:16])));
			endcase
			emit(itype_word(OP_SW, 0, rd, 4 * slot));
			slot++;
			prev = rd;
		end
		// loads with an immediate consumer
		sec_start[3] = pc_idx;
		for (k = 0; k < 4; k++) begin
			addr = LOAD_BASE + 4 * int'(next_random() % 64);
			emit(itype_word(OP_LW, 0, 1, addr));
			emit(rtype_word(FN_ADDU, 2, 1, 3));
			emit(itype_word(OP_SW, 0, 2, 4 * slot));
			slot++;
			addr = (k % 2 == 1) ? 4 * (slot - 1) : LOAD_BASE + 4 * int'(next_random() % 64);
			emit(itype_word(OP_LW, 0, 4, addr));
			emit(itype_word(OP_SW, 0, 4, 4 * slot));
			slot++;
		end
		// branches with stores marking delay slot, fall-through and target
		sec_start[4] = pc_idx;
		for (k = 0; k < 6; k++) begin
			r = next_random();
			emit(itype_word(OP_ADDIU, 0, 8, int'(r[15:0])));
			if (k % 3 == 2) begin
				if (k % 2 == 0) begin
					emit(itype_word(OP_SW, 0, 8, 4 * slot));
					slot++;
					addr = 4 * (slot - 1);
				end else begin
					addr = LOAD_BASE + 4 * int'(r[25:20]);
				end
				emit(itype_word(OP_LW, 0, 9, addr));
			end else begin
				emit(itype_word(OP_ADDIU, 8, 9, k % 2));
			end
			// even k compares equal, so beq and bne each go both ways
			if ((k / 2) % 2 == 1)
				emit(itype_word(OP_BNE, 8, 9, 2));
			else
				emit(itype_word(OP_BEQ, 8, 9, 2));
			emit(itype_word(OP_SW, 0, 8, 4 * slot));
			emit(itype_word(OP_SW, 0, 9, 4 * (slot + 1)));
			emit(itype_word(OP_SW, 0, 8, 4 * (slot + 2)));
			slot += 3;
		end
		// call and return followed by a plain jump
		sec_start[5] = pc_idx;
		k = pc_idx;
		emit(jtype_word(OP_JAL, k + 6));
		emit(itype_word(OP_SW, 0, 1, 4 * slot));
		emit(itype_word(OP_SW, 0, 31, 4 * (slot + 1)));
		emit(jtype_word(OP_J, k + 9));
		emit(itype_word(OP_SW, 0, 2, 4 * (slot + 2)));
		emit(itype_word(OP_SW, 0, 3, 4 * (slot + 3)));
		emit(itype_word(OP_SW, 0, 4, 4 * (slot + 4)));
		emit(rtype_word(FN_JR, 0, 31, 0));
		emit(itype_word(OP_SW, 0, 5, 4 * (slot + 5)));
		// halt loop
		halt_pc = 32'(pc_idx * 4);
		emit(jtype_word(OP_J, pc_idx));
		emit(32'h0);
	endtask

	// isa interpreter with one delay slot
	function automatic int run_model();
		logic [31:0] regs [0:31];
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] nxt;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] ea;
		int          steps;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < RAM_WORDS; i++)
			model_mem[i] = fill_word(i);
		pc = `CORE_RESET_PC;
		npc = pc + 4;
		steps = 0;
		n_exp = 0;
		while (pc != halt_pc && steps < MAX_STEPS) begin
			w   = rom[pc[10:2]];
			a   = regs[w[25:21]];
			b   = regs[w[20:16]];
			imm = {{16{w[15]}}, w[15:0]};
			ea  = a + imm;
			nxt = npc + 4;
			case (w[31:26])
				OP_RTYPE: begin
					case (w[5:0])
						FN_ADDU: regs[w[15:11]] = a + b;
						FN_SUBU: regs[w[15:11]] = a - b;
						FN_AND:  regs[w[15:11]] = a & b;
						FN_OR:   regs[w[15:11]] = a | b;
						FN_SLT:  regs[w[15:11]] = 32'($signed(a) < $signed(b));
						FN_JR:   nxt = a;
						default: ;
					endcase
				end
				OP_ADDIU: regs[w[20:16]] = ea;
				OP_LUI:   regs[w[20:16]] = {w[15:0], 16'h0};
				OP_LW:    regs[w[20:16]] = model_mem[ea[9:2]];
				OP_SW: begin
					model_mem[ea[9:2]] = b;
					exp_addr[n_exp] = ea;
					exp_data[n_exp] = b;
					exp_test[n_exp] = section_of(pc);
					n_exp++;
				end
				OP_BEQ: if (a == b) nxt = pc + 4 + (imm << 2);
				OP_BNE: if (a != b) nxt = pc + 4 + (imm << 2);
				OP_J:   nxt = {npc[31:28], w[25:0], 2'b00};
				OP_JAL: begin
					regs[31] = pc + 8;
					nxt = {npc[31:28], w[25:0], 2'b00};
				end
				default: ;
			endcase
			regs[0] = '0;
			pc = npc;
			npc = nxt;
			steps++;
		end
		return steps;
	endfunction

	task automatic report_test(int t);
		if (test_errs[t] == 0) begin
			passed++;
			$display("test %0d %s: passed", t, test_name[t]);
		end else begin
			failed++;
			$display("test %0d %s: failed with %0d errors", t, test_name[t], test_errs[t]);
		end
	endtask

	// store stream compared mid-cycle
	always @(negedge clk) begin
		if (rst_n && o_dmem_we) begin
			assert (n_seen < n_exp) else begin
				$display("unexpected extra store to address %h at time %0t", o_dmem_addr, $time);
				errors++;
			end
			if (n_seen < n_exp) begin
				store_tag = exp_test[n_seen];
				assert (o_dmem_addr == exp_addr[n_seen] && o_dmem_wdata == exp_data[n_seen])
				else begin
					$display("CHECK FAILED at %0t: store %0d expected [%h]=%h, seen [%h]=%h",
						$time, n_seen, exp_addr[n_seen], exp_data[n_seen],
						o_dmem_addr, o_dmem_wdata);
					errors++;
					test_errs[store_tag]++;
				end
				if (n_seen == n_exp - 1 || exp_test[n_seen + 1] != store_tag)
					report_test(store_tag);
			end
			n_seen++;
		end
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("watchdog: the program did not finish within %0d cycles", limit_cycles);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		errors = 0;
		passed = 0;
		failed = 0;
		n_seen = 0;
		limit_cycles = 0;
		test_name[1] = "reset state";
		test_name[2] = "alu forwarding";
		test_name[3] = "load-use stall";
		test_name[4] = "branches and delay slots";
		test_name[5] = "jal, jr and j";
		test_name[6] = "final memory image";
		for (int i = 1; i <= 6; i++)
			test_errs[i] = 0;
		for (int i = 0; i < ROM_WORDS; i++)
			rom[i] = '0;
		for (int i = 0; i < RAM_WORDS; i++)
			ram[i] = fill_word(i);
		build_program();
		n_steps = run_model();
		limit_cycles = n_steps * 4 + 64;

		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
		assert (o_dmem_we === 1'b0 && o_dmem_re === 1'b0 && o_imem_addr === `CORE_RESET_PC)
		else begin
			$display("CHECK FAILED at %0t: after reset we=%b re=%b imem_addr=%h",
				$time, o_dmem_we, o_dmem_re, o_imem_addr);
			errors++;
			test_errs[1]++;
		end
		report_test(1);

		// done once every store is seen and fetch sits in the halt loop
		while (!(n_seen >= n_exp && o_imem_addr == halt_pc)) begin
			@(posedge clk);
			#2;
		end

		for (int i = 0; i < RAM_WORDS; i++) begin
			assert (ram[i] == model_mem[i]) else begin
				$display("CHECK FAILED at %0t: memory word %0d expected %h, seen %h",
					$time, i, model_mem[i], ram[i]);
				errors++;
				test_errs[6]++;
			end
		end
		report_test(6);

		$display("summary: %0d tests, %0d passed, %0d failed, %0d check errors, %0d stores",
			passed + failed, passed, failed, errors, n_seen);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+include
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/fetch.sv
hw/reg_file.sv
hw/decode.sv
hw/execute.sv
hw/mem_stage.sv
hw/core.sv
verif/core_tb.sv

/* Bender.yml */
package:
  name: mips_core

export_include_dirs:
  - include

sources:
  - hw/isa_pkg.sv
  - hw/pipe_pkg.sv
  - hw/fetch.sv
  - hw/reg_file.sv
  - hw/decode.sv
  - hw/execute.sv
  - hw/mem_stage.sv
  - hw/core.sv
  - target: test
    files:
      - verif/core_tb.sv
